//--- compile.f
+incdir+test
design/apple1_map_pkg.sv
design/apple1_ctrl_pkg.sv
design/apple1_cfg_regs.sv
design/apple1_clken.sv
design/apple1_mem_bus.sv
design/apple1_tape_audio.sv
design/apple1_board_top.sv
test/apple1_tb.sv

//--- design/apple1_board_top.sv
// on-board logic around an external 6502 core
// cpu bus, download and cfg ports are single-cycle strobes,
// no back-pressure, every strobe is taken in its cycle
// all inputs are assumed synchronous to sys_clock
module apple1_board_top (
	input  logic                       sys_clock,
	input  logic                       arst_n_i,
	input  apple1_map_pkg::addr_t      cpu_addr_i,
	input  apple1_map_pkg::data_t      cpu_wdata_i,
	input  logic                       cpu_wr_i,
	input  logic                       cpu_rd_i,
	input  logic                       dl_wr_i,
	input  apple1_map_pkg::dl_addr_t   dl_addr_i,
	input  apple1_map_pkg::data_t      dl_data_i,
	input  logic                       cfg_wr_i,
	input  apple1_ctrl_pkg::cfg_byte_t cfg_data_i,
	input  logic                       button_i,
	input  logic                       reset_key_i,
	input  logic                       tape_in_i,
	input  logic                       tape_out_i,
	output apple1_map_pkg::data_t      rdata_o,
	output logic                       rdata_valid_o,
	output logic                       cpu_clken_o,
	output logic                       core_reset_o,
	output logic                       led_o,
	output logic                       audio_o
);
	import apple1_ctrl_pkg::*;

	cfg_t cfg;  // decoded status for the audio block

	apple1_cfg_regs u_apple1_cfg_regs (
		.sys_clock    (sys_clock),
		.arst_n_i     (arst_n_i),
		.cfg_wr_i     (cfg_wr_i),
		.cfg_data_i   (cfg_data_i),
		.button_i     (button_i),
		.reset_key_i  (reset_key_i),
		.cfg_o        (cfg),
		.core_reset_o (core_reset_o)
	);

	apple1_clken u_apple1_clken (
		.sys_clock    (sys_clock),
		.arst_n_i     (arst_n_i),
		.core_reset_i (core_reset_o),  // restart phase with the core
		.cpu_clken_o  (cpu_clken_o)
	);

	apple1_mem_bus u_apple1_mem_bus (
		.sys_clock     (sys_clock),
		.arst_n_i      (arst_n_i),
		.cpu_addr_i    (cpu_addr_i),
		.cpu_wdata_i   (cpu_wdata_i),
		.cpu_wr_i      (cpu_wr_i),
		.cpu_rd_i      (cpu_rd_i),
		.dl_wr_i       (dl_wr_i),
		.dl_addr_i     (dl_addr_i),
		.dl_data_i     (dl_data_i),
		.rdata_o       (rdata_o),
		.rdata_valid_o (rdata_valid_o),
		.led_o         (led_o)
	);

	apple1_tape_audio u_apple1_tape_audio (
		.sys_clock  (sys_clock),
		.arst_n_i   (arst_n_i),
		.cfg_i      (cfg),
		.tape_in_i  (tape_in_i),
		.tape_out_i (tape_out_i),
		.audio_o    (audio_o)
	);

endmodule

//--- design/apple1_cfg_regs.sv
// status register and core reset generation
// the reset key only counts on its rising edge, so holding the key
// gives a single reset pulse and not a stuck core
// button_i is expected to be synchronous to sys_clock
module apple1_cfg_regs (
	input  logic                      sys_clock,
	input  logic                      arst_n_i,
	input  logic                      cfg_wr_i,
	input  apple1_ctrl_pkg::cfg_byte_t cfg_data_i,
	input  logic                      button_i,
	input  logic                      reset_key_i,
	output apple1_ctrl_pkg::cfg_t     cfg_o,
	output logic                      core_reset_o
);
	import apple1_ctrl_pkg::*;

	cfg_byte_t status_q;     // status byte
	logic      reset_key_q;  // key level one cycle back
	logic      key_edge;
	logic      reset_req;

	// status byte, loaded on strobe
	always_ff @(posedge sys_clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			status_q <= '0;  // tape in monitored after reset
		end else if (cfg_wr_i) begin
			status_q <= cfg_data_i;
		end
	end

	// rising edge of the keyboard reset key
	always_ff @(posedge sys_clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			reset_key_q <= 1'b0;
		end else begin
			reset_key_q <= reset_key_i;
		end
	end

	assign key_edge  = reset_key_i & ~reset_key_q;  // one-cycle pulse
	assign reset_req = cfg_o.menu_reset | button_i | key_edge;

	// registered so a one-cycle key edge still gives a clean pulse
	always_ff @(posedge sys_clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			core_reset_o <= 1'b1;  // core held in reset with the board
		end else begin
			core_reset_o <= reset_req;
		end
	end

	assign cfg_o.menu_reset   = status_q[CFG_MENU_RESET_BIT];
	assign cfg_o.mon_tape_out = status_q[CFG_MON_TAPE_BIT];

endmodule

//--- design/apple1_clken.sv
// cpu phase-2 clock enable from sys_clock
// one pulse every CPU_CLKEN_DIV cycles, output registered
// counter held at zero through core reset, first pulse comes
// CPU_CLKEN_DIV cycles after core reset drops
module apple1_clken (
	input  logic sys_clock,
	input  logic arst_n_i,
	input  logic core_reset_i,
	output logic cpu_clken_o
);
	import apple1_ctrl_pkg::*;

	clken_cnt_t cnt_q;    // position inside one cpu cycle
	logic       cnt_last;

	assign cnt_last = (cnt_q == CLKEN_LAST);

	always_ff @(posedge sys_clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q <= '0;
		end else if (core_reset_i) begin
			cnt_q <= '0;  // restart with the core
		end else if (cnt_last) begin
			cnt_q <= '0;  // wrap
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	// enable lands one cycle after the last count
	always_ff @(posedge sys_clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cpu_clken_o <= 1'b0;
		end else begin
			cpu_clken_o <= cnt_last & ~core_reset_i;
		end
	end

endmodule

//--- design/apple1_ctrl_pkg.sv
// control side definitions: clock enable, status byte, tape dac
// status byte bit positions follow the menu option order
// bits not listed are stored but have no function
package apple1_ctrl_pkg;

	localparam int CPU_CLKEN_DIV = 56;  // sys_clock cycles per cpu enable
	localparam int CLKEN_CNT_W   = $clog2(CPU_CLKEN_DIV);
	localparam int DAC_W         = 16;  // sigma-delta input width

	typedef logic [CLKEN_CNT_W-1:0] clken_cnt_t;
	typedef logic [DAC_W-1:0]       dac_word_t;

	localparam clken_cnt_t CLKEN_LAST = clken_cnt_t'(CPU_CLKEN_DIV - 1);

	// raw status byte as written over cfg strobe
	typedef logic [7:0] cfg_byte_t;

	localparam int CFG_MON_TAPE_BIT   = 3;  // audio monitor select
	localparam int CFG_MENU_RESET_BIT = 6;  // menu reset entry

	// decoded status
	typedef struct packed {
		logic menu_reset;    // active high
		logic mon_tape_out;  // 1 tape out, 0 tape in
	} cfg_t;

endpackage

//--- design/apple1_map_pkg.sv
// Apple-1 memory map as seen from the 6502 side
// only the three on-chip regions are decoded; 0x4000-0xBFFF and the
// I/O page fall into the unmapped region and read back as zero
// download addresses are limited to the 16-bit CPU space
package apple1_map_pkg;

	typedef logic [15:0] addr_t;     // cpu address
	typedef logic [7:0]  data_t;     // bus byte
	typedef logic [15:0] dl_addr_t;  // download address, cpu space only

	// decoded bus regions
	typedef enum logic [1:0] {
		REGION_LOW_RAM = 2'd0,
		REGION_BASIC   = 2'd1,
		REGION_ROM     = 2'd2,
		REGION_NONE    = 2'd3
	} region_e;

	// region bounds
	localparam addr_t LOW_RAM_END = 16'h3FFF;  // 0x0000 -> 0x3FFF
	localparam addr_t BASIC_BASE  = 16'hE000;  // basic ram start
	localparam addr_t BASIC_END   = 16'hEFFF;
	localparam addr_t ROM_BASE    = 16'hFF00;  // monitor page up to 0xFFFF

	// memory address widths
	localparam int LOW_RAM_AW = 14;  // 16 KB
	localparam int BASIC_AW   = 12;  // 4 KB
	localparam int ROM_AW     = 8;   // one page

	// address to region, first match wins
	function automatic region_e decode_region(addr_t addr);
		region_e region;
		if (addr <= LOW_RAM_END)
			region = REGION_LOW_RAM;
		else if (addr >= BASIC_BASE && addr <= BASIC_END)
			region = REGION_BASIC;
		else if (addr >= ROM_BASE)
			region = REGION_ROM;
		else
			region = REGION_NONE;  // sdram window, aci, unused io
		return region;
	endfunction

endpackage

//--- design/apple1_mem_bus.sv
// memory bus: download/cpu arbitration, region decode, on-chip memories
// download write beats any cpu access in the same cycle, the cpu one is lost
// reads have one cycle latency and may be issued every cycle
// rom page is only writable by download, cpu writes there are dropped
// unmapped regions read as zero, memory content is undefined at power up
module apple1_mem_bus (
	input  logic                      sys_clock,
	input  logic                      arst_n_i,
	input  apple1_map_pkg::addr_t     cpu_addr_i,
	input  apple1_map_pkg::data_t     cpu_wdata_i,
	input  logic                      cpu_wr_i,
	input  logic                      cpu_rd_i,
	input  logic                      dl_wr_i,
	input  apple1_map_pkg::dl_addr_t  dl_addr_i,
	input  apple1_map_pkg::data_t     dl_data_i,
	output apple1_map_pkg::data_t     rdata_o,
	output logic                      rdata_valid_o,
	output logic                      led_o
);
	import apple1_map_pkg::*;

	// on-chip memories
	data_t low_mem   [2**LOW_RAM_AW];
	data_t basic_mem [2**BASIC_AW];
	data_t rom_mem   [2**ROM_AW];

	// bus as seen after arbitration
	addr_t   bus_addr;
	data_t   bus_wdata;
	logic    bus_wr;
	logic    bus_rd;
	region_e bus_region;

	// per-region write enables
	logic low_we;
	logic basic_we;
	logic rom_we;

	// read pipeline
	region_e rd_region_q;  // region of the read in flight
	data_t   low_q;
	data_t   basic_q;
	data_t   rom_q;

	// download has priority
	always_comb begin
		if (dl_wr_i) begin
			bus_addr  = addr_t'(dl_addr_i);
			bus_wdata = dl_data_i;
			bus_wr    = 1'b1;
			bus_rd    = 1'b0;  // cpu read dropped, no valid
		end else begin
			bus_addr  = cpu_addr_i;
			bus_wdata = cpu_wdata_i;
			bus_wr    = cpu_wr_i;
			bus_rd    = cpu_rd_i;
		end
	end

	assign bus_region = decode_region(bus_addr);

	assign low_we   = bus_wr && (bus_region == REGION_LOW_RAM);
	assign basic_we = bus_wr && (bus_region == REGION_BASIC);
	assign rom_we   = dl_wr_i && (bus_region == REGION_ROM);  // download only

	// activity led, lit (low) during download writes
	assign led_o = ~dl_wr_i;

	// memory writes
	always_ff @(posedge sys_clock) begin
		if (low_we)
			low_mem[bus_addr[LOW_RAM_AW-1:0]] <= bus_wdata;
		if (basic_we)
			basic_mem[bus_addr[BASIC_AW-1:0]] <= bus_wdata;
		if (rom_we)
			rom_mem[bus_addr[ROM_AW-1:0]] <= bus_wdata;
	end

	// synchronous reads, only on a granted read strobe
	always_ff @(posedge sys_clock) begin
		if (bus_rd) begin
			low_q       <= low_mem[bus_addr[LOW_RAM_AW-1:0]];
			basic_q     <= basic_mem[bus_addr[BASIC_AW-1:0]];
			rom_q       <= rom_mem[bus_addr[ROM_AW-1:0]];
			rd_region_q <= bus_region;  // steers the mux next cycle
		end
	end

	always_ff @(posedge sys_clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rdata_valid_o <= 1'b0;
		end else begin
			rdata_valid_o <= bus_rd;
		end
	end

	// read mux
	always_comb begin
		case (rd_region_q)
			REGION_LOW_RAM: rdata_o = low_q;
			REGION_BASIC:   rdata_o = basic_q;
			REGION_ROM:     rdata_o = rom_q;
			default:        rdata_o = '0;  // not implemented here
		endcase
	end

endmodule

//--- design/apple1_tape_audio.sv
// tape monitor to one-bit audio
// cassette input latched inverted, one cycle late
// first-order sigma-delta, monitor bit drives the dac msb only,
// so a high bit gives 50 % pulse density and a low bit gives none
module apple1_tape_audio (
	input  logic                  sys_clock,
	input  logic                  arst_n_i,
	input  apple1_ctrl_pkg::cfg_t cfg_i,
	input  logic                  tape_in_i,
	input  logic                  tape_out_i,
	output logic                  audio_o
);
	import apple1_ctrl_pkg::*;

	logic       tape_in_q;  // inverted cassette level
	logic       mon_bit;
	dac_word_t  dac_in;
	logic [DAC_W:0] acc_q;  // accumulator plus carry

	always_ff @(posedge sys_clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			tape_in_q <= 1'b0;
		end else begin
			tape_in_q <= ~tape_in_i;
		end
	end

	assign mon_bit = cfg_i.mon_tape_out ? tape_out_i : tape_in_q;
	assign dac_in  = {mon_bit, {(DAC_W-1){1'b0}}};  // bit on the msb

	// carry of each add becomes the audio bit
	always_ff @(posedge sys_clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			acc_q <= '0;
		end else begin
			acc_q <= {1'b0, acc_q[DAC_W-1:0]} + {1'b0, dac_in};
		end
	end

	assign audio_o = acc_q[DAC_W];  // straight from the register

endmodule

//--- run_sim.sh
#!/bin/sh
# builds apple1_tb with Verilator, runs it, then searches sim.log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module apple1_tb -f compile.f \
	-Mdir obj_dir -o apple1_sim > build.log 2>&1 \
	|| { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/apple1_sim > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -qx "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- test/apple1_tb_util.svh
// testbench helpers, included inside apple1_tb after both package imports
// reference memory covers the whole cpu space, rom page written by download only
// unmapped space reads zero, bytes never written stay x in the model
`ifndef APPLE1_TB_UTIL_SVH
`define APPLE1_TB_UTIL_SVH

localparam logic [31:0] LFSR_TAPS = 32'h80200003;  // x^32+x^22+x^2+x+1

logic [31:0] lfsr_state = 32'he9760a31;
data_t       ref_mem [0:65535];  // expected bytes
int          value_errs = 0;     // wrong signal values
int          other_errs = 0;     // counts and intervals

// one galois step, returns the bit shifted out
function automatic logic lfsr_bit();
	logic out;
	out = lfsr_state[0];
	lfsr_state = lfsr_state >> 1;
	if (out)
		lfsr_state = lfsr_state ^ LFSR_TAPS;
	return out;
endfunction

// n fresh bits, one step each
function automatic logic [31:0] rand_bits(int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
		v = {v[30:0], lfsr_bit()};
	return v;
endfunction

function automatic bit is_ram(addr_t a);
	return (a <= LOW_RAM_END) || (a >= BASIC_BASE && a <= BASIC_END);
endfunction

function automatic bit is_rom(addr_t a);
	return a >= ROM_BASE;  // monitor page
endfunction

function automatic void model_write(addr_t a, data_t d, bit from_dl);
	if (is_ram(a) || (is_rom(a) && from_dl))
		ref_mem[a] = d;
endfunction

function automatic data_t model_read(addr_t a);
	return (is_ram(a) || is_rom(a)) ? ref_mem[a] : 8'h00;
endfunction

task automatic report_value(string name, logic [15:0] got, logic [15:0] exp);
	value_errs++;
	$display("ERR %0t %s got %0h exp %0h", $time, name, got, exp);
endtask

task automatic report_other(string what);
	other_errs++;
	$display("%0t: %s", $time, what);
endtask

task automatic expect_bit(string name, logic got, logic e);
	assert (got === e) else report_value(name, 16'(got), 16'(e));
endtask

`endif

//--- test/apple1_tb.sv
// testbench for apple1_board_top
// strobes are driven 1 unit after the rising edge, registered outputs
// are checked at that same point, led_o at the falling edge
// memory reads only target bytes written earlier in the run
module apple1_tb;
	import apple1_map_pkg::*;
	import apple1_ctrl_pkg::*;

	typedef enum int {OP_IDLE, OP_DL, OP_WR, OP_RD, OP_DL_WR, OP_DL_RD} op_e;

	typedef struct {
		op_e   op;
		addr_t addr;
		data_t data;
		data_t exp;  // read result, OP_RD only
	} row_t;

	`include "apple1_tb_util.svh"

	logic      sys_clock = 1'b0;
	logic      arst_n_i;
	addr_t     cpu_addr_i;
	data_t     cpu_wdata_i;
	logic      cpu_wr_i;
	logic      cpu_rd_i;
	logic      dl_wr_i;
	dl_addr_t  dl_addr_i;
	data_t     dl_data_i;
	logic      cfg_wr_i;
	cfg_byte_t cfg_data_i;
	logic      button_i;
	logic      reset_key_i;
	logic      tape_in_i;
	logic      tape_out_i;
	data_t     rdata_o;
	logic      rdata_valid_o;
	logic      cpu_clken_o;
	logic      core_reset_o;
	logic      led_o;
	logic      audio_o;

	row_t rows[$];        // stimulus table
	int   cycles = 0;
	int   cycle_limit = 0;  // set once the table is built

	apple1_board_top u_apple1_board_top (
		.sys_clock     (sys_clock),
		.arst_n_i      (arst_n_i),
		.cpu_addr_i    (cpu_addr_i),
		.cpu_wdata_i   (cpu_wdata_i),
		.cpu_wr_i      (cpu_wr_i),
		.cpu_rd_i      (cpu_rd_i),
		.dl_wr_i       (dl_wr_i),
		.dl_addr_i     (dl_addr_i),
		.dl_data_i     (dl_data_i),
		.cfg_wr_i      (cfg_wr_i),
		.cfg_data_i    (cfg_data_i),
		.button_i      (button_i),
		.reset_key_i   (reset_key_i),
		.tape_in_i     (tape_in_i),
		.tape_out_i    (tape_out_i),
		.rdata_o       (rdata_o),
		.rdata_valid_o (rdata_valid_o),
		.cpu_clken_o   (cpu_clken_o),
		.core_reset_o  (core_reset_o),
		.led_o         (led_o),
		.audio_o       (audio_o)
	);

	always #5 sys_clock = ~sys_clock;

	always @(posedge sys_clock)
		cycles <= cycles + 1;

	// led lit only with a download strobe
	always @(negedge sys_clock) begin
		assert (led_o === !dl_wr_i) else report_value("led_o", 16'(led_o), 16'(!dl_wr_i));
	end

	task automatic step();
		@(posedge sys_clock);
		#1;
	endtask

	// table row, model follows the same writes in the same order
	function automatic void add_row(op_e op, addr_t a, data_t d, data_t e);
		row_t r;
		r = '{op, a, d, e};
		rows.push_back(r);
		if (op == OP_DL || op == OP_DL_WR || op == OP_DL_RD)
			model_write(a, d, 1'b1);  // cpu side of a shared cycle is lost
		else if (op == OP_WR)
			model_write(a, d, 1'b0);
	endfunction

	function automatic void build_table();
		addr_t ra [12];
		// downloads into all three regions, back-to-back reads after
		add_row(OP_DL, 16'h0000, 8'h11, 8'h00);
		add_row(OP_DL, 16'h3FFF, 8'h22, 8'h00);
		add_row(OP_DL, 16'hE000, 8'h33, 8'h00);
		add_row(OP_DL, 16'hEFFF, 8'h44, 8'h00);
		add_row(OP_DL, 16'hFF00, 8'h55, 8'h00);
		add_row(OP_DL, 16'hFFFF, 8'h66, 8'h00);
		add_row(OP_IDLE, 16'h0000, 8'h00, 8'h00);
		add_row(OP_RD, 16'h0000, 8'h00, 8'h11);
		add_row(OP_RD, 16'h3FFF, 8'h00, 8'h22);
		add_row(OP_RD, 16'hE000, 8'h00, 8'h33);
		add_row(OP_RD, 16'hEFFF, 8'h00, 8'h44);
		add_row(OP_RD, 16'hFF00, 8'h00, 8'h55);
		add_row(OP_RD, 16'hFFFF, 8'h00, 8'h66);
		add_row(OP_IDLE, 16'h0000, 8'h00, 8'h00);
		// cpu writes, each read straight behind
		add_row(OP_WR, 16'h1234, 8'hA5, 8'h00);
		add_row(OP_RD, 16'h1234, 8'h00, 8'hA5);
		add_row(OP_WR, 16'hE800, 8'h5A, 8'h00);
		add_row(OP_RD, 16'hE800, 8'h00, 8'h5A);
		add_row(OP_WR, 16'hFF00, 8'h99, 8'h00);  // rom page, ignored
		add_row(OP_RD, 16'hFF00, 8'h00, 8'h55);
		// unmapped space
		add_row(OP_RD, 16'h4000, 8'h00, 8'h00);
		add_row(OP_RD, 16'h8000, 8'h00, 8'h00);
		add_row(OP_RD, 16'hBFFF, 8'h00, 8'h00);
		add_row(OP_RD, 16'hC000, 8'h00, 8'h00);
		add_row(OP_RD, 16'hF000, 8'h00, 8'h00);
		// download against cpu in one cycle, cpu side hits addr+1
		add_row(OP_WR, 16'h0201, 8'hC3, 8'h00);
		add_row(OP_DL_WR, 16'h0200, 8'h77, 8'h00);
		add_row(OP_RD, 16'h0200, 8'h00, 8'h77);
		add_row(OP_RD, 16'h0201, 8'h00, 8'hC3);  // cpu write was lost
		add_row(OP_DL_RD, 16'h0300, 8'h88, 8'h00);  // no valid next cycle
		add_row(OP_RD, 16'h0300, 8'h00, 8'h88);
		add_row(OP_IDLE, 16'h0000, 8'h00, 8'h00);
		// random downloads, regions in turn, then read back
		for (int i = 0; i < 12; i++) begin
			case (i % 3)
				0: ra[i] = addr_t'(rand_bits(LOW_RAM_AW));
				1: ra[i] = BASIC_BASE | addr_t'(rand_bits(BASIC_AW));
				default: ra[i] = ROM_BASE | addr_t'(rand_bits(ROM_AW));
			endcase
			add_row(OP_DL, ra[i], data_t'(rand_bits(8)), 8'h00);
		end
		for (int i = 0; i < 12; i++)
			add_row(OP_RD, ra[i], 8'h00, model_read(ra[i]));
	endfunction

	task automatic drive_row(row_t r);
		dl_wr_i     = (r.op == OP_DL || r.op == OP_DL_WR || r.op == OP_DL_RD);
		dl_addr_i   = r.addr;
		dl_data_i   = r.data;
		cpu_wr_i    = (r.op == OP_WR || r.op == OP_DL_WR);
		cpu_rd_i    = (r.op == OP_RD || r.op == OP_DL_RD);
		cpu_addr_i  = (r.op == OP_DL_WR || r.op == OP_DL_RD) ? r.addr + 16'd1 : r.addr;
		cpu_wdata_i = (r.op == OP_DL_WR) ? ~r.data : r.data;  // dropped anyway
	endtask

	// result of the strobe from the row before
	task automatic check_read(bit pend, data_t exp);
		expect_bit("rdata_valid_o", rdata_valid_o, pend);
		if (pend)
			assert (rdata_o === exp) else report_value("rdata_o", 16'(rdata_o), 16'(exp));
	endtask

	task automatic run_table();
		bit    pend;
		data_t pend_exp;
		pend = 1'b0;
		pend_exp = '0;
		foreach (rows[i]) begin
			step();
			check_read(pend, pend_exp);
			drive_row(rows[i]);
			pend = (rows[i].op == OP_RD);
			pend_exp = rows[i].exp;
		end
		step();
		check_read(pend, pend_exp);
		dl_wr_i  = 1'b0;
		cpu_wr_i = 1'b0;
		cpu_rd_i = 1'b0;
	endtask

	task automatic check_clken();
		int gap;
		while (core_reset_o)
			step();
		// first gap counts from the fall of core reset
		for (int p = 0; p < 4; p++) begin
			gap = 0;
			do begin
				step();
				gap++;
			end while (!cpu_clken_o);
			assert (gap == CPU_CLKEN_DIV) else
				report_other($sformatf("cpu_clken_o pulse came after %0d cycles, not %0d",
					gap, CPU_CLKEN_DIV));
		end
	endtask

	task automatic write_cfg(cfg_byte_t v);
		cfg_wr_i = 1'b1;
		cfg_data_i = v;
		step();
		cfg_wr_i = 1'b0;  // status loaded at that edge
	endtask

	task automatic check_core_reset();
		expect_bit("core_reset_o", core_reset_o, 1'b0);
		button_i = 1'b1;
		step();
		expect_bit("core_reset_o", core_reset_o, 1'b1);
		button_i = 1'b0;
		step();
		expect_bit("core_reset_o", core_reset_o, 1'b0);
		reset_key_i = 1'b1;  // held, one pulse only
		step();
		expect_bit("core_reset_o", core_reset_o, 1'b1);
		repeat (3) begin
			step();
			expect_bit("core_reset_o", core_reset_o, 1'b0);
		end
		reset_key_i = 1'b0;
		write_cfg(cfg_byte_t'(1 << CFG_MENU_RESET_BIT));
		expect_bit("core_reset_o", core_reset_o, 1'b0);  // one cycle behind the status
		repeat (4) begin
			step();
			expect_bit("core_reset_o", core_reset_o, 1'b1);
		end
		write_cfg(8'h00);
		step();
		expect_bit("core_reset_o", core_reset_o, 1'b0);
	endtask

	task automatic count_audio(int lo, int hi, string what);
		int ones;
		ones = 0;
		repeat (4) step();  // latch and accumulator settle
		repeat (64) begin
			step();
			if (audio_o)
				ones++;
		end
		assert (ones >= lo && ones <= hi) else
			report_other($sformatf("%s: audio_o had %0d ones in 64 cycles, expected %0d to %0d",
				what, ones, lo, hi));
	endtask

	task automatic check_audio();
		tape_in_i = 1'b0;  // inverted on latch, bit high
		count_audio(31, 33, "tape in low");
		tape_in_i = 1'b1;
		count_audio(0, 0, "tape in high");
		write_cfg(cfg_byte_t'(1 << CFG_MON_TAPE_BIT));
		tape_out_i = 1'b1;
		count_audio(31, 33, "tape out high");
		tape_out_i = 1'b0;
		count_audio(0, 0, "tape out low");
	endtask

	initial begin
		arst_n_i    = 1'b0;
		cpu_addr_i  = '0;
		cpu_wdata_i = '0;
		cpu_wr_i    = 1'b0;
		cpu_rd_i    = 1'b0;
		dl_wr_i     = 1'b0;
		dl_addr_i   = '0;
		dl_data_i   = '0;
		cfg_wr_i    = 1'b0;
		cfg_data_i  = '0;
		button_i    = 1'b0;
		reset_key_i = 1'b0;
		tape_in_i   = 1'b1;  // quiet audio to start
		tape_out_i  = 1'b0;
		build_table();
		cycle_limit = rows.size() * 4 + 600;
		repeat (10) @(posedge sys_clock);
		#1;
		expect_bit("rdata_valid_o", rdata_valid_o, 1'b0);
		expect_bit("cpu_clken_o", cpu_clken_o, 1'b0);
		expect_bit("audio_o", audio_o, 1'b0);
		expect_bit("core_reset_o", core_reset_o, 1'b1);
		arst_n_i = 1'b1;
		check_clken();
		run_table();
		check_core_reset();
		check_audio();
		$display("value errors: %0d, other errors: %0d", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// watchdog on the cycle count
	initial begin
		wait (cycle_limit != 0);
		while (cycles < cycle_limit)
			@(posedge sys_clock);
		$display("timeout after %0d cycles, the run did not complete", cycles);
		$display("Simulation failed");
		$finish;
	end

endmodule
